/* cpu_pkg.sv */
package cpu_pkg;

	//////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////

	localparam int word_width     = 32;  // Instruction and PC width
	localparam int alu_op_width   = 4;   // Low field of the execute bus
	localparam int exec_bus_width = 7;
	localparam int mem_bus_width  = 3;
	localparam int wb_bus_width   = 2;

	// Execute bus bit positions, ALU op sits in 3:0
	localparam int exec_alu_src    = 4;
	localparam int exec_reg_dst    = 5;
	localparam int exec_shamt_flag = 6;

	// Memory bus bit positions
	localparam int mem_write_bit   = 0;
	localparam int mem_read_bit    = 1;
	localparam int mem_branch_bit  = 2;

	// Write-back bus bit positions
	localparam int wb_mem_to_reg   = 0;
	localparam int wb_reg_write    = 1;

	//////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////

	typedef enum logic [alu_op_width-1:0] {
		alu_sll  = 4'd0,
		alu_srl  = 4'd1,
		alu_sra  = 4'd2,
		alu_add  = 4'd3,
		alu_and  = 4'd4,
		alu_or   = 4'd5,
		alu_xor  = 4'd6,
		alu_nor  = 4'd7,
		alu_sub  = 4'd8,
		alu_slt  = 4'd9,
		alu_none = 4'd15   // No operation
	} alu_op_e;

	localparam alu_op_e alu_lui = alu_sll;  // LUI shares code 0 with sll

	// Major opcode class, opcode bits 5:3
	typedef enum logic [2:0] {
		class_special   = 3'b000,  // R-type, branches, jumps
		class_immediate = 3'b001,
		class_load      = 3'b100,
		class_store     = 3'b101
	} op_class_e;

	localparam logic [word_width-1:0] nop_word = '0;  // Bubble instruction

endpackage

/* fetch_if.sv */
`timescale 1ns/1ps

// IF/ID slot as seen by the decode side
interface fetch_if import cpu_pkg::*; ();

	logic [word_width-1:0] instr;  // Fetched word, nop_word in a bubble
	logic [word_width-1:0] pc;     // Address of instr
	logic                  nop;    // Slot holds a bubble

	// Buffer side
	modport driver (
		output instr,
		output pc,
		output nop
	);

	// Decoder and ID/EX register
	modport decode (
		input instr,
		input pc,
		input nop
	);

endinterface

/* pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import cpu_pkg::*; #(
	parameter logic [word_width-1:0] reset_pc = '0
)(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  instr_valid,  // Word offered this cycle
	input  logic                  stall,        // Decode side full
	input  logic                  redirect,     // One-cycle flush pulse
	input  logic [word_width-1:0] redirect_pc,
	output logic [word_width-1:0] pc
);

	logic accept;  // Fetch taken this edge
	logic [word_width-1:0] pc_next;

	assign accept = instr_valid && !stall;

	//////////////////////////////////////////////////
	// Next address
	//////////////////////////////////////////////////

	always_comb
	begin
		pc_next = pc;  // Hold by default
		if (redirect)
		begin
			pc_next = redirect_pc;  // Redirect wins over stepping
		end
		else if (accept)
		begin
			pc_next = pc + word_width'(4);  // One word per fetch
		end
	end

	//////////////////////////////////////////////////
	// Fetch address register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pc <= reset_pc;
		end
		else
		begin
			pc <= pc_next;
		end
	end

endmodule

/* if_id_buffer.sv */
`timescale 1ns/1ps

module if_id_buffer import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  instr_valid,  // Strobe for instr
	input  logic [word_width-1:0] instr,
	input  logic [word_width-1:0] pc,           // Address of instr
	input  logic                  stall,        // Hold the slot
	input  logic                  redirect,     // Flush the slot
	fetch_if.driver               fetch
);

	logic accept;  // Same condition the PC unit steps on

	assign accept = instr_valid && !stall && !redirect;

	//////////////////////////////////////////////////
	// Slot contents and bubble marker
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			fetch.instr <= nop_word;  // Start empty
			fetch.nop   <= 1'b1;
		end
		else if (redirect)
		begin
			fetch.instr <= nop_word;  // Wrong-path word dropped
			fetch.nop   <= 1'b1;
		end
		else if (stall)
		begin
			fetch.instr <= fetch.instr;  // Keep word until decode frees up
			fetch.nop   <= fetch.nop;
		end
		else if (instr_valid)
		begin
			fetch.instr <= instr;
			fetch.nop   <= 1'b0;
		end
		else
		begin
			// Nothing offered, slot goes empty
			fetch.instr <= nop_word;
			fetch.nop   <= 1'b1;
		end
	end

	// Address travels with its word
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			fetch.pc <= pc;
		end
	end

endmodule

/* decoder.sv */
`timescale 1ns/1ps

module decoder import cpu_pkg::*; (
	fetch_if.decode                     fetch,
	output logic [exec_bus_width-1:0]   execute_bus,
	output logic [mem_bus_width-1:0]    memory_bus,
	output logic [wb_bus_width-1:0]     wb_bus
);

	logic [5:0] opcode;
	logic [5:0] funct;
	op_class_e  op_class;

	// Individual control bits before packing
	alu_op_e alu_op;
	logic    alu_src;      // Immediate operand
	logic    reg_dst;      // 1 writes rd, 0 writes rt
	logic    shamt_flag;   // Shift amount or offset path
	logic    mem_write;
	logic    mem_read;
	logic    branch_flag;  // Branch or jump
	logic    mem_to_reg;   // Write back load data
	logic    reg_write;

	assign opcode   = fetch.instr[31:26];
	assign funct    = fetch.instr[5:0];
	assign op_class = op_class_e'(opcode[5:3]);

	//////////////////////////////////////////////////
	// Control rules
	//////////////////////////////////////////////////

	always_comb
	begin
		// Everything off unless a class turns it on
		alu_op      = alu_none;
		alu_src     = 1'b0;
		reg_dst     = 1'b0;
		shamt_flag  = 1'b0;
		mem_write   = 1'b0;
		mem_read    = 1'b0;
		branch_flag = 1'b0;
		mem_to_reg  = 1'b0;
		reg_write   = 1'b0;

		case (op_class)
			class_special:
			begin
				reg_dst = 1'b1;  // Result to rd
				case (opcode[2:0])
					3'b000:  // R-type
					begin
						case (funct)
							6'b000000:
							begin
								alu_op     = alu_sll;
								shamt_flag = 1'b1;  // Shift by shamt
							end
							6'b000010:
							begin
								alu_op     = alu_srl;
								shamt_flag = 1'b1;
							end
							6'b000011:
							begin
								alu_op     = alu_sra;
								shamt_flag = 1'b1;
							end
							6'b000100: alu_op = alu_sll;  // Variable shifts
							6'b000110: alu_op = alu_srl;
							6'b000111: alu_op = alu_sra;
							6'b100001: alu_op = alu_add;  // addu
							6'b100011: alu_op = alu_sub;  // subu
							6'b100100: alu_op = alu_and;
							6'b100101: alu_op = alu_or;
							6'b100110: alu_op = alu_xor;
							6'b100111: alu_op = alu_nor;
							6'b101010: alu_op = alu_slt;
							default:   alu_op = alu_none;
						endcase
						reg_write = !fetch.nop;  // Bubble writes nothing
						if (funct == 6'b001000 || funct == 6'b001001)
						begin
							reg_write = 1'b0;  // jr and jalr
						end
					end
					default:
					begin
						branch_flag = 1'b1;  // beq, bne and jumps take the PC path
					end
				endcase
			end
			class_load,
			class_store:
			begin
				alu_op     = alu_add;  // Base plus offset
				alu_src    = 1'b1;
				shamt_flag = 1'b1;
				if (op_class == class_store)
				begin
					mem_write = 1'b1;
				end
				else
				begin
					mem_read   = 1'b1;
					mem_to_reg = 1'b1;  // Load data to rt
					reg_write  = 1'b1;
				end
			end
			class_immediate:
			begin
				case (opcode[2:0])
					3'b000:  alu_op = alu_add;
					3'b010:  alu_op = alu_slt;
					3'b100:  alu_op = alu_and;
					3'b101:  alu_op = alu_or;
					3'b110:  alu_op = alu_xor;
					3'b111:  alu_op = alu_lui;
					default: alu_op = alu_none;
				endcase
				alu_src   = 1'b1;  // Immediate operand, result to rt
				reg_write = 1'b1;
			end
			default:
			begin
				alu_op = alu_none;  // Unknown class stays idle
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Bus packing
	//////////////////////////////////////////////////

	always_comb
	begin
		execute_bus                     = '0;
		execute_bus[alu_op_width-1:0]   = alu_op;
		execute_bus[exec_alu_src]       = alu_src;
		execute_bus[exec_reg_dst]       = reg_dst;
		execute_bus[exec_shamt_flag]    = shamt_flag;
		memory_bus                      = '0;
		memory_bus[mem_write_bit]       = mem_write;
		memory_bus[mem_read_bit]        = mem_read;
		memory_bus[mem_branch_bit]      = branch_flag;
		wb_bus                          = '0;
		wb_bus[wb_mem_to_reg]           = mem_to_reg;
		wb_bus[wb_reg_write]            = reg_write;
	end

endmodule

/* id_ex_register.sv */
`timescale 1ns/1ps

module id_ex_register import cpu_pkg::*; (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      stall,        // Feed a bubble onward
	fetch_if.decode                   fetch,
	input  logic [exec_bus_width-1:0] execute_bus,
	input  logic [mem_bus_width-1:0]  memory_bus,
	input  logic [wb_bus_width-1:0]   wb_bus,
	output logic                      ex_valid,
	output alu_op_e                   ex_alu_op,
	output logic                      ex_alu_src,
	output logic                      ex_reg_dst,
	output logic                      ex_shamt,
	output logic                      ex_mem_read,
	output logic                      ex_mem_write,
	output logic                      ex_branch,
	output logic                      ex_mem_to_reg,
	output logic                      ex_reg_write,
	output logic [4:0]                ex_rs,
	output logic [4:0]                ex_rt,
	output logic [4:0]                ex_rd,
	output logic [word_width-1:0]     ex_imm,
	output logic [word_width-1:0]     ex_pc
);

	logic bubble;

	assign bubble = stall || fetch.nop;  // No live word this edge

	//////////////////////////////////////////////////
	// Control fields
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ex_valid      <= 1'b0;
			ex_alu_op     <= alu_none;
			ex_alu_src    <= 1'b0;
			ex_reg_dst    <= 1'b0;
			ex_shamt      <= 1'b0;
			ex_mem_read   <= 1'b0;
			ex_mem_write  <= 1'b0;
			ex_branch     <= 1'b0;
			ex_mem_to_reg <= 1'b0;
			ex_reg_write  <= 1'b0;
		end
		else if (bubble)
		begin
			ex_valid      <= 1'b0;
			ex_alu_op     <= alu_none;  // Idle ALU
			ex_alu_src    <= 1'b0;
			ex_reg_dst    <= 1'b0;
			ex_shamt      <= 1'b0;
			ex_mem_read   <= 1'b0;
			ex_mem_write  <= 1'b0;
			ex_branch     <= 1'b0;
			ex_mem_to_reg <= 1'b0;
			ex_reg_write  <= 1'b0;
		end
		else
		begin
			ex_valid      <= 1'b1;
			ex_alu_op     <= alu_op_e'(execute_bus[alu_op_width-1:0]);
			ex_alu_src    <= execute_bus[exec_alu_src];
			ex_reg_dst    <= execute_bus[exec_reg_dst];
			ex_shamt      <= execute_bus[exec_shamt_flag];
			ex_mem_read   <= memory_bus[mem_read_bit];
			ex_mem_write  <= memory_bus[mem_write_bit];
			ex_branch     <= memory_bus[mem_branch_bit];
			ex_mem_to_reg <= wb_bus[wb_mem_to_reg];
			ex_reg_write  <= wb_bus[wb_reg_write];
		end
	end

	// Operand fields, meaningful only with ex_valid
	always_ff @(posedge clk)
	begin
		ex_rs  <= fetch.instr[25:21];
		ex_rt  <= fetch.instr[20:16];
		ex_rd  <= fetch.instr[15:11];
		ex_imm <= {{(word_width-16){fetch.instr[15]}}, fetch.instr[15:0]};  // Sign extend
		ex_pc  <= fetch.pc;
	end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; #(
	parameter logic [word_width-1:0] reset_pc = '0  // First fetch address
)(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  instr_valid,
	input  logic [word_width-1:0] instr,
	input  logic                  stall,
	input  logic                  redirect,
	input  logic [word_width-1:0] redirect_pc,
	output logic                  ex_valid,
	output alu_op_e               ex_alu_op,
	output logic                  ex_alu_src,
	output logic                  ex_reg_dst,
	output logic                  ex_shamt,
	output logic                  ex_mem_read,
	output logic                  ex_mem_write,
	output logic                  ex_branch,
	output logic                  ex_mem_to_reg,
	output logic                  ex_reg_write,
	output logic [4:0]            ex_rs,
	output logic [4:0]            ex_rt,
	output logic [4:0]            ex_rd,
	output logic [word_width-1:0] ex_imm,
	output logic [word_width-1:0] ex_pc
);

	logic [word_width-1:0]     pc;           // Current fetch address
	logic [exec_bus_width-1:0] execute_bus;
	logic [mem_bus_width-1:0]  memory_bus;
	logic [wb_bus_width-1:0]   wb_bus;

	fetch_if fetch ();  // IF/ID slot

	pc_unit #(
		.reset_pc (reset_pc)
	) u_pc_unit (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pc          (pc)
	);

	if_id_buffer u_if_id_buffer (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.stall       (stall),
		.redirect    (redirect),
		.fetch       (fetch.driver)
	);

	decoder u_decoder (
		.fetch       (fetch.decode),
		.execute_bus (execute_bus),
		.memory_bus  (memory_bus),
		.wb_bus      (wb_bus)
	);

	id_ex_register u_id_ex_register (
		.clk           (clk),
		.arst_n        (arst_n),
		.stall         (stall),
		.fetch         (fetch.decode),
		.execute_bus   (execute_bus),
		.memory_bus    (memory_bus),
		.wb_bus        (wb_bus),
		.ex_valid      (ex_valid),
		.ex_alu_op     (ex_alu_op),
		.ex_alu_src    (ex_alu_src),
		.ex_reg_dst    (ex_reg_dst),
		.ex_shamt      (ex_shamt),
		.ex_mem_read   (ex_mem_read),
		.ex_mem_write  (ex_mem_write),
		.ex_branch     (ex_branch),
		.ex_mem_to_reg (ex_mem_to_reg),
		.ex_reg_write  (ex_reg_write),
		.ex_rs         (ex_rs),
		.ex_rt         (ex_rt),
		.ex_rd         (ex_rd),
		.ex_imm        (ex_imm),
		.ex_pc         (ex_pc)
	);

endmodule

/* tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage import cpu_pkg::*; ();

	localparam logic [31:0] start_pc = 32'h00400000;

	typedef struct packed {
		logic [31:0] word;      // Template, fields filled when fill is set
		logic        valid;
		logic        stall;
		logic        redirect;
		logic [31:0] rpc;
		logic        fill;      // Random rs, rt, rd, shamt, immediate
		int          test;
	} row_t;

	logic        clk;
	logic        arst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic        stall;
	logic        redirect;
	logic [31:0] redirect_pc;
	logic        ex_valid;
	alu_op_e     ex_alu_op;
	logic        ex_alu_src;
	logic        ex_reg_dst;
	logic        ex_shamt;
	logic        ex_mem_read;
	logic        ex_mem_write;
	logic        ex_branch;
	logic        ex_mem_to_reg;
	logic        ex_reg_write;
	logic [4:0]  ex_rs;
	logic [4:0]  ex_rt;
	logic [4:0]  ex_rd;
	logic [31:0] ex_imm;
	logic [31:0] ex_pc;
	logic [11:0] dut_ctrl;  // Same packing as ref_control

	row_t        stim_table[$];
	string       test_names[$];
	int          errors = 0;
	int          checks = 0;
	int          test_errors_start = 0;
	int          cycle_count = 0;
	int          cycle_limit = 1000;  // Replaced once the table is built
	int unsigned seed_dummy;
	logic [31:0] applied_word;

	// Reference pipeline state
	logic [31:0] m_pc;
	logic [31:0] slot_word;
	logic [31:0] slot_pc;
	logic        slot_nop;
	logic        exp_valid;
	logic [11:0] exp_ctrl;
	logic [31:0] exp_word;
	logic [31:0] exp_pc;

	assign dut_ctrl = {ex_alu_op, ex_alu_src, ex_reg_dst, ex_shamt, ex_mem_read,
		ex_mem_write, ex_branch, ex_mem_to_reg, ex_reg_write};

	decode_stage #(
		.reset_pc (start_pc)
	) uut (
		.clk (clk), .arst_n (arst_n), .instr_valid (instr_valid), .instr (instr),
		.stall (stall), .redirect (redirect), .redirect_pc (redirect_pc),
		.ex_valid (ex_valid), .ex_alu_op (ex_alu_op), .ex_alu_src (ex_alu_src),
		.ex_reg_dst (ex_reg_dst), .ex_shamt (ex_shamt), .ex_mem_read (ex_mem_read),
		.ex_mem_write (ex_mem_write), .ex_branch (ex_branch),
		.ex_mem_to_reg (ex_mem_to_reg), .ex_reg_write (ex_reg_write),
		.ex_rs (ex_rs), .ex_rt (ex_rt), .ex_rd (ex_rd), .ex_imm (ex_imm), .ex_pc (ex_pc)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout after %0d cycles, the run never reached its end", cycle_count);
			$display("TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Control rules, {alu_op, alu_src, reg_dst, shamt,
	// mem_read, mem_write, branch, mem_to_reg, reg_write}
	//////////////////////////////////////////////////

	function automatic logic [11:0] ref_control(input logic [31:0] w);
		logic [5:0] op;
		logic [5:0] fn;
		logic [3:0] alu;
		logic [7:0] bits;
		op   = w[31:26];
		fn   = w[5:0];
		alu  = alu_none;
		bits = 8'b0;
		case (op[5:3])
			3'b000:
			begin
				bits[6] = 1'b1;  // reg_dst over the whole special class
				if (op[2:0] == 3'b000)
				begin
					case (fn)
						6'h00: alu = alu_sll;
						6'h02: alu = alu_srl;
						6'h03: alu = alu_sra;
						6'h04: alu = alu_sll;
						6'h06: alu = alu_srl;
						6'h07: alu = alu_sra;
						6'h21: alu = alu_add;
						6'h23: alu = alu_sub;
						6'h24: alu = alu_and;
						6'h25: alu = alu_or;
						6'h26: alu = alu_xor;
						6'h27: alu = alu_nor;
						6'h2a: alu = alu_slt;
						default: alu = alu_none;
					endcase
					bits[5] = (fn == 6'h00 || fn == 6'h02 || fn == 6'h03);  // Fixed shifts
					bits[0] = !(fn == 6'h08 || fn == 6'h09);  // jr, jalr write nothing
				end
				else
				begin
					bits[2] = 1'b1;  // Branches and jumps
				end
			end
			3'b100:
			begin
				alu  = alu_add;
				bits = 8'b1011_0011;  // Load
			end
			3'b101:
			begin
				alu  = alu_add;
				bits = 8'b1010_1000;  // Store
			end
			3'b001:
			begin
				case (op[2:0])
					3'b000: alu = alu_add;
					3'b010: alu = alu_slt;
					3'b100: alu = alu_and;
					3'b101: alu = alu_or;
					3'b110: alu = alu_xor;
					3'b111: alu = alu_lui;
					default: alu = alu_none;
				endcase
				bits = 8'b1000_0001;
			end
			default: alu = alu_none;
		endcase
		return {alu, bits};
	endfunction

	//////////////////////////////////////////////////
	// Table building
	//////////////////////////////////////////////////

	task automatic add_row(input logic [31:0] word, input logic valid_in, input logic stall_in,
		input logic redir_in, input logic [31:0] rpc_in, input logic fill_in);
		row_t r;
		r.word     = word;
		r.valid    = valid_in;
		r.stall    = stall_in;
		r.redirect = redir_in;
		r.rpc      = rpc_in;
		r.fill     = fill_in;
		r.test     = test_names.size();
		stim_table.push_back(r);
	endtask

	// Plain accepted word with random fields
	task automatic add_word(input logic [31:0] word);
		add_row(word, 1'b1, 1'b0, 1'b0, 32'h0, 1'b1);
	endtask

	// Two idle cycles drain the pipeline before the next test
	task automatic close_test(input string name);
		add_row(32'h0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
		add_row(32'h0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
		test_names.push_back(name);
	endtask

	task automatic build_table();
		// R-type funct codes
		add_word(32'h00000000);
		add_word(32'h00000002);
		add_word(32'h00000003);
		add_word(32'h00000004);
		add_word(32'h00000006);
		add_word(32'h00000007);
		add_word(32'h00000021);
		add_word(32'h00000023);
		add_word(32'h00000024);
		add_word(32'h00000025);
		add_word(32'h00000026);
		add_word(32'h00000027);
		add_word(32'h0000002a);
		add_word(32'h00000008);  // jr
		add_word(32'h00000009);  // jalr
		add_word(32'h00000020);  // Funct outside the table
		close_test("rtype funct");
		add_word(32'h8c000000);  // lw
		add_word(32'ha0000000);  // sb
		add_row(32'h8c85fffc, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);  // Negative offset
		add_row(32'h20a47fff, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);  // Largest positive
		add_word(32'h20000000);
		add_word(32'h24000000);  // addiu, no ALU code
		add_word(32'h28000000);
		add_word(32'h30000000);
		add_word(32'h34000000);
		add_word(32'h38000000);
		add_word(32'h3c000000);  // lui
		close_test("memory and immediate");
		add_word(32'h10000000);
		add_word(32'h14000000);
		add_word(32'h08000000);
		add_word(32'h0c000000);
		add_word(32'h40000000);  // Unknown classes
		add_word(32'hfc000000);
		close_test("branch jump unknown");
		add_word(32'h00000021);
		add_word(32'h00000024);
		add_row(32'h00000025, 1'b1, 1'b0, 1'b1, 32'h00800000, 1'b1);  // Dropped by flush
		add_word(32'h8c000000);
		add_word(32'h0000002a);
		close_test("redirect");
		add_word(32'h00000021);
		add_word(32'h8c000000);
		add_row(32'hac000000, 1'b1, 1'b1, 1'b0, 32'h0, 1'b1);  // Offered during stall
		add_row(32'hac000000, 1'b1, 1'b1, 1'b0, 32'h0, 1'b1);
		add_row(32'h00000000, 1'b0, 1'b1, 1'b0, 32'h0, 1'b0);
		add_word(32'h20000000);
		add_row(32'h00000000, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);  // Gap
		add_word(32'h30000000);
		close_test("stall and idle");
	endtask

	//////////////////////////////////////////////////
	// Drive, model, compare
	//////////////////////////////////////////////////

	task automatic apply_row(input row_t r);
		logic [31:0] mask;
		mask = (r.word[31:26] == 6'd0) ? 32'h03ffffc0 : 32'h03ffffff;  // Keep funct
		applied_word = r.fill ? ((r.word & ~mask) | ($urandom & mask)) : r.word;
		instr_valid  = r.valid;
		instr        = applied_word;
		stall        = r.stall;
		redirect     = r.redirect;
		redirect_pc  = r.rpc;
	endtask

	task automatic step_model(input row_t r, input logic [31:0] w);
		exp_valid = !(r.stall || slot_nop);  // ID/EX takes the old slot
		exp_ctrl  = exp_valid ? ref_control(slot_word) : {alu_none, 8'b0};
		exp_word  = slot_word;
		exp_pc    = slot_pc;
		if (r.redirect)
		begin
			slot_nop = 1'b1;
		end
		else if (!r.stall)
		begin
			slot_nop  = !r.valid;
			slot_word = w;
			slot_pc   = m_pc;
		end
		if (r.redirect)
			m_pc = r.rpc;
		else if (r.valid && !r.stall)
			m_pc = m_pc + 32'd4;
	endtask

	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_outputs();
		compare_field("ex_valid", ex_valid, exp_valid);
		compare_field("control", dut_ctrl, exp_ctrl);
		if (exp_valid)
		begin
			compare_field("ex_rs", ex_rs, exp_word[25:21]);
			compare_field("ex_rt", ex_rt, exp_word[20:16]);
			compare_field("ex_rd", ex_rd, exp_word[15:11]);
			compare_field("ex_imm", ex_imm, {{16{exp_word[15]}}, exp_word[15:0]});
			compare_field("ex_pc", ex_pc, exp_pc);
		end
	endtask

	task automatic report_test(input int num, input string name);
		if (errors == test_errors_start)
			$display("Test %0d %s: ok", num, name);
		else
			$display("Test %0d %s: %0d errors", num, name, errors - test_errors_start);
		test_errors_start = errors;
	endtask

	initial
	begin
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = 32'h0;
		stall       = 1'b0;
		redirect    = 1'b0;
		redirect_pc = 32'h0;
		seed_dummy  = $urandom(32'h58b52882);
		build_table();
		cycle_limit = stim_table.size() * 4 + 100;
		m_pc        = start_pc;
		slot_word   = 32'h0;
		slot_pc     = 32'h0;
		slot_nop    = 1'b1;
		repeat (10) @(posedge clk);
		#2;
		arst_n = 1'b1;
		compare_field("ex_valid", ex_valid, 32'h0);  // Reset state
		compare_field("ex_mem_read", ex_mem_read, 32'h0);
		compare_field("ex_mem_write", ex_mem_write, 32'h0);
		compare_field("ex_branch", ex_branch, 32'h0);
		compare_field("ex_reg_write", ex_reg_write, 32'h0);
		report_test(0, "reset state");
		for (int i = 0; i < stim_table.size(); i++)
		begin
			apply_row(stim_table[i]);
			@(posedge clk);
			#2;
			step_model(stim_table[i], applied_word);
			check_outputs();
			if (i == stim_table.size() - 1 || stim_table[i + 1].test != stim_table[i].test)
				report_test(stim_table[i].test + 1, test_names[stim_table[i].test]);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* build.f */
cpu_pkg.sv
fetch_if.sv
pc_unit.sv
if_id_buffer.sv
decoder.sv
id_ex_register.sv
decode_stage.sv
tb_decode_stage.sv
